// File: include/md_defs.svh
// shared widths and encoding constants for the M-extension pipeline, included by the RTL files
`ifndef MD_DEFS_SVH
`define MD_DEFS_SVH

// datapath width
`define MD_XLEN 32

// register file addressing
`define MD_RADDR_W 5
`define MD_NREGS 32

// major opcode of register-register ops
`define MD_OPCODE_OP 7'b011_0011

// funct7 marking an M-extension instruction
`define MD_FUNCT7_M 7'b000_0001

// divider iteration counter, wide enough to count MD_XLEN steps
`define MD_DIV_CNT_W 6

`endif

// File: hw/md_pkg.sv
// types shared by the M-extension pipeline modules, imported where an enum is needed
package md_pkg;

  // decoded M-extension operation
  typedef enum logic [3:0] {
    MD_OP_MUL,
    MD_OP_MULH,
    MD_OP_MULHSU,
    MD_OP_MULHU,
    MD_OP_DIV,
    MD_OP_DIVU,
    MD_OP_REM,
    MD_OP_REMU,
    MD_OP_NONE
  } md_op_e;

  // iterative divider FSM
  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_RUN,
    DIV_DONE
  } div_state_e;

endpackage

// File: hw/md_decoder.sv
// combinational decode of an instruction word into the M operation, unit select and signedness
`timescale 1ns/1ps
`include "md_defs.svh"

module md_decoder (
  input  logic [`MD_XLEN-1:0] insn_i,
  output md_pkg::md_op_e      op_o,
  output logic                mult_sel_o,
  output logic                div_sel_o,
  output logic                signed_a_o,
  output logic                signed_b_o
);
  import md_pkg::*;

  logic [6:0] opcode;
  logic [6:0] funct7;
  logic [2:0] funct3;
  logic       is_m;

  assign opcode = insn_i[6:0];
  assign funct3 = insn_i[14:12];
  assign funct7 = insn_i[31:25];
  assign is_m   = (opcode == `MD_OPCODE_OP) && (funct7 == `MD_FUNCT7_M);

  always_comb begin
    op_o       = MD_OP_NONE;
    mult_sel_o = 1'b0;
    div_sel_o  = 1'b0;
    if (is_m) begin
      // funct3[2] splits multiply from divide
      mult_sel_o = ~funct3[2];
      div_sel_o  = funct3[2];
      case (funct3)
        3'b000:  op_o = MD_OP_MUL;
        3'b001:  op_o = MD_OP_MULH;
        3'b010:  op_o = MD_OP_MULHSU;
        3'b011:  op_o = MD_OP_MULHU;
        3'b100:  op_o = MD_OP_DIV;
        3'b101:  op_o = MD_OP_DIVU;
        3'b110:  op_o = MD_OP_REM;
        default: op_o = MD_OP_REMU;
      endcase
    end
  end

  // mulhsu treats only rs1 as signed
  assign signed_a_o = (op_o == MD_OP_MULH) || (op_o == MD_OP_MULHSU) ||
                      (op_o == MD_OP_DIV) || (op_o == MD_OP_REM);
  assign signed_b_o = (op_o == MD_OP_MULH) || (op_o == MD_OP_DIV) || (op_o == MD_OP_REM);

endmodule

// File: hw/md_multiplier.sv
// single-cycle multiplier, operands captured on start and the product word selected the next cycle
`timescale 1ns/1ps
`include "md_defs.svh"

module md_multiplier (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                start_i,
  input  md_pkg::md_op_e      op_i,
  input  logic                signed_a_i,
  input  logic                signed_b_i,
  input  logic [`MD_XLEN-1:0] a_i,
  input  logic [`MD_XLEN-1:0] b_i,
  output logic [`MD_XLEN-1:0] result_o
);
  import md_pkg::*;

  localparam int ProdW = 2 * `MD_XLEN;

  md_op_e                   op_q;
  logic signed [`MD_XLEN:0] a_q;
  logic signed [`MD_XLEN:0] b_q;
  logic signed [ProdW-1:0]  prod;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      op_q <= MD_OP_NONE;
    end else if (start_i) begin
      op_q <= op_i;
    end
  end

  // 33-bit operands cover both signed and unsigned ranges
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      a_q <= {signed_a_i & a_i[`MD_XLEN-1], a_i};
      b_q <= {signed_b_i & b_i[`MD_XLEN-1], b_i};
    end
  end

  // low 64 bits of the signed product are exact for every op
  assign prod = ProdW'(a_q) * ProdW'(b_q);

  assign result_o = (op_q == MD_OP_MUL) ? prod[`MD_XLEN-1:0] : prod[ProdW-1:`MD_XLEN];

endmodule

// File: hw/md_divider.sv
// iterative restoring divider that yields one quotient bit per cycle and finishes early on special cases
`timescale 1ns/1ps
`include "md_defs.svh"

module md_divider (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                flush_i,
  input  logic                start_i,
  input  md_pkg::md_op_e      op_i,
  input  logic                signed_i,
  input  logic [`MD_XLEN-1:0] a_i,
  input  logic [`MD_XLEN-1:0] b_i,
  output logic                done_o,
  output logic [`MD_XLEN-1:0] result_o
);
  import md_pkg::*;

  localparam int W = `MD_XLEN;
  localparam logic [`MD_DIV_CNT_W-1:0] LastCnt = `MD_DIV_CNT_W'(`MD_XLEN - 1);

  div_state_e               state_q;
  logic [`MD_DIV_CNT_W-1:0] cnt_q;
  logic [W-1:0]             quo_q;
  logic [W-1:0]             rem_q;
  logic [W-1:0]             div_q;
  logic                     neg_quo_q;
  logic                     neg_rem_q;
  logic                     rem_sel_q;

  logic                     a_neg;
  logic                     b_neg;
  logic [W-1:0]             a_mag;
  logic [W-1:0]             b_mag;
  logic                     div_zero;
  logic                     overflow;
  logic [W:0]               rem_sh;
  logic                     sub_ok;
  logic [W-1:0]             rem_sub;
  logic [W-1:0]             quo_fix;
  logic [W-1:0]             rem_fix;

  // operand magnitudes
  assign a_neg = signed_i & a_i[W-1];
  assign b_neg = signed_i & b_i[W-1];
  assign a_mag = a_neg ? -a_i : a_i;
  assign b_mag = b_neg ? -b_i : b_i;

  assign div_zero = (b_i == '0);
  // most negative value divided by -1
  assign overflow = signed_i && (a_i == {1'b1, {(W-1){1'b0}}}) && (b_i == '1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= DIV_IDLE;
      cnt_q   <= '0;
    end else if (flush_i) begin
      state_q <= DIV_IDLE;
    end else if (start_i) begin
      state_q <= (div_zero | overflow) ? DIV_DONE : DIV_RUN;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        DIV_RUN: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == LastCnt) begin
            state_q <= DIV_DONE;
          end
        end
        DIV_DONE: state_q <= DIV_DONE;
        default:  state_q <= DIV_IDLE;
      endcase
    end
  end

  // one restoring step
  assign rem_sh  = {rem_q, quo_q[W-1]};
  assign sub_ok  = (rem_sh >= {1'b0, div_q});
  assign rem_sub = rem_sh[W-1:0] - div_q;

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      div_q     <= b_mag;
      rem_sel_q <= (op_i == MD_OP_REM) || (op_i == MD_OP_REMU);
      if (div_zero) begin
        quo_q     <= '1;
        rem_q     <= a_i;
        neg_quo_q <= 1'b0;
        neg_rem_q <= 1'b0;
      end else if (overflow) begin
        quo_q     <= a_i;
        rem_q     <= '0;
        neg_quo_q <= 1'b0;
        neg_rem_q <= 1'b0;
      end else begin
        quo_q     <= a_mag;
        rem_q     <= '0;
        neg_quo_q <= a_neg ^ b_neg;
        neg_rem_q <= a_neg;
      end
    end else if (state_q == DIV_RUN) begin
      quo_q <= {quo_q[W-2:0], sub_ok};
      rem_q <= sub_ok ? rem_sub : rem_sh[W-1:0];
    end
  end

  // remainder takes the sign of the dividend
  assign quo_fix = neg_quo_q ? -quo_q : quo_q;
  assign rem_fix = neg_rem_q ? -rem_q : rem_q;

  assign done_o   = (state_q == DIV_DONE);
  assign result_o = rem_sel_q ? rem_fix : quo_fix;

endmodule

// File: hw/md_wb_stage.sv
// writeback register toward commit, with its own ready and the forwarding reservation vector
`timescale 1ns/1ps
`include "md_defs.svh"

module md_wb_stage (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   flush_i,
  input  logic                   in_valid_i,
  input  logic                   in_we_i,
  input  logic [`MD_RADDR_W-1:0] in_rd_i,
  input  logic [`MD_XLEN-1:0]    in_data_i,
  input  logic [`MD_XLEN-1:0]    in_pc_i,
  input  logic                   in_fwd_ok_i,
  input  logic                   waw_valid_i,
  input  logic [`MD_RADDR_W-1:0] waw_rd_i,
  input  logic                   ds_rdy_i,
  output logic                   rdy_o,
  output logic                   valid_o,
  output logic                   we_o,
  output logic [`MD_RADDR_W-1:0] rd_o,
  output logic [`MD_XLEN-1:0]    data_o,
  output logic [`MD_XLEN-1:0]    pc_o,
  output logic [`MD_NREGS-1:0]   fwd_act_o
);

  logic                   valid_q;
  logic                   fwd_q;
  logic                   we_q;
  logic [`MD_RADDR_W-1:0] rd_q;
  logic [`MD_XLEN-1:0]    data_q;
  logic [`MD_XLEN-1:0]    pc_q;
  logic                   load;
  logic                   waw_match;

  assign rdy_o     = ~valid_q | ds_rdy_i;
  assign load      = in_valid_i & rdy_o;
  assign waw_match = waw_valid_i && (waw_rd_i == rd_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      fwd_q   <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
      fwd_q   <= 1'b0;
    end else if (rdy_o) begin
      valid_q <= in_valid_i;
      fwd_q   <= in_valid_i & in_fwd_ok_i & in_we_i & (in_rd_i != '0);
    end else if (waw_match) begin
      // a newer writer owns rd now, result still retires
      fwd_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      we_q   <= in_we_i;
      rd_q   <= in_rd_i;
      data_q <= in_data_i;
      pc_q   <= in_pc_i;
    end
  end

  // one-hot reservation, x0 never reserved
  always_comb begin
    fwd_act_o = '0;
    for (int i = 1; i < `MD_NREGS; i++) begin
      fwd_act_o[i] = valid_q & fwd_q & (rd_q == `MD_RADDR_W'(i));
    end
  end

  assign valid_o = valid_q;
  assign we_o    = we_q;
  assign rd_o    = rd_q;
  assign data_o  = data_q;
  assign pc_o    = pc_q;

endmodule

// File: hw/md_pipeline.sv
// top of the three-stage multiply/divide pipeline between the issuer and the commit stage
`timescale 1ns/1ps
`include "md_defs.svh"

module md_pipeline (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   flush_i,
  input  logic                   us_valid_i,
  input  logic [`MD_XLEN-1:0]    insn_i,
  input  logic [`MD_XLEN-1:0]    pc_i,
  input  logic [`MD_XLEN-1:0]    rs1_data_i,
  input  logic [`MD_XLEN-1:0]    rs2_data_i,
  output logic                   rdy_o,
  input  logic                   waw_valid_i,
  input  logic [`MD_RADDR_W-1:0] waw_rd_i,
  input  logic                   ds_rdy_i,
  output logic                   valid_o,
  output logic                   wb_we_o,
  output logic [`MD_RADDR_W-1:0] wb_rd_o,
  output logic [`MD_XLEN-1:0]    wb_data_o,
  output logic [`MD_XLEN-1:0]    wb_pc_o,
  output logic [`MD_NREGS-1:0]   fwd_act_o
);
  import md_pkg::*;

  md_op_e                 dec_op;
  logic                   dec_mult_sel;
  logic                   dec_div_sel;
  logic                   dec_signed_a;
  logic                   dec_signed_b;
  logic                   accept;

  logic                   ex2_valid_q;
  logic                   ex2_mult_q;
  logic                   ex2_div_q;
  logic                   ex2_fwd_ok_q;
  logic                   ex2_we_q;
  logic [`MD_RADDR_W-1:0] ex2_rd_q;
  logic [`MD_XLEN-1:0]    ex2_pc_q;
  logic                   op_done;
  logic                   op_done_q;
  logic                   ex2_waw_match;
  logic [`MD_XLEN-1:0]    ex2_result;

  logic [`MD_XLEN-1:0]    mult_result;
  logic [`MD_XLEN-1:0]    div_result;
  logic                   div_done;
  logic                   wb_rdy;

  md_decoder u_decoder (
    .insn_i     (insn_i),
    .op_o       (dec_op),
    .mult_sel_o (dec_mult_sel),
    .div_sel_o  (dec_div_sel),
    .signed_a_o (dec_signed_a),
    .signed_b_o (dec_signed_b)
  );

  // EX1: units start on the accepting edge
  assign accept = us_valid_i & rdy_o;

  md_multiplier u_multiplier (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .start_i    (accept & dec_mult_sel),
    .op_i       (dec_op),
    .signed_a_i (dec_signed_a),
    .signed_b_i (dec_signed_b),
    .a_i        (rs1_data_i),
    .b_i        (rs2_data_i),
    .result_o   (mult_result)
  );

  md_divider u_divider (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .flush_i  (flush_i),
    .start_i  (accept & dec_div_sel),
    .op_i     (dec_op),
    .signed_i (dec_signed_a),
    .a_i      (rs1_data_i),
    .b_i      (rs2_data_i),
    .done_o   (div_done),
    .result_o (div_result)
  );

  // EX2: only a divide can take more than one cycle
  assign op_done       = ~ex2_div_q | div_done | op_done_q;
  assign rdy_o         = ~ex2_valid_q | (op_done & wb_rdy);
  assign ex2_waw_match = waw_valid_i && (waw_rd_i == ex2_rd_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ex2_valid_q  <= 1'b0;
      ex2_mult_q   <= 1'b0;
      ex2_div_q    <= 1'b0;
      ex2_fwd_ok_q <= 1'b0;
      op_done_q    <= 1'b0;
    end else if (flush_i) begin
      ex2_valid_q  <= 1'b0;
      ex2_fwd_ok_q <= 1'b0;
      op_done_q    <= 1'b0;
    end else if (rdy_o) begin
      ex2_valid_q  <= us_valid_i;
      ex2_mult_q   <= dec_mult_sel;
      ex2_div_q    <= dec_div_sel;
      ex2_fwd_ok_q <= 1'b1;
      op_done_q    <= 1'b0;
    end else begin
      // keep done across a WB stall
      if (ex2_valid_q & op_done) begin
        op_done_q <= 1'b1;
      end
      if (ex2_waw_match) begin
        ex2_fwd_ok_q <= 1'b0;
      end
    end
  end

  // non-M words still retire, just without a register write
  always_ff @(posedge clk_i) begin
    if (accept) begin
      ex2_we_q <= (dec_op != MD_OP_NONE);
      ex2_rd_q <= insn_i[7 +: `MD_RADDR_W];
      ex2_pc_q <= pc_i;
    end
  end

  assign ex2_result = ex2_mult_q ? mult_result :
                      ex2_div_q  ? div_result  : '0;

  md_wb_stage u_wb_stage (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .in_valid_i  (ex2_valid_q & op_done),
    .in_we_i     (ex2_we_q),
    .in_rd_i     (ex2_rd_q),
    .in_data_i   (ex2_result),
    .in_pc_i     (ex2_pc_q),
    .in_fwd_ok_i (ex2_fwd_ok_q & ~ex2_waw_match),
    .waw_valid_i (waw_valid_i),
    .waw_rd_i    (waw_rd_i),
    .ds_rdy_i    (ds_rdy_i),
    .rdy_o       (wb_rdy),
    .valid_o     (valid_o),
    .we_o        (wb_we_o),
    .rd_o        (wb_rd_o),
    .data_o      (wb_data_o),
    .pc_o        (wb_pc_o),
    .fwd_act_o   (fwd_act_o)
  );

endmodule

// File: dv/tb_md_pipeline.sv
// simulation top that replays dv/md_testdata.txt into md_pipeline under random back-pressure
`timescale 1ns/1ps
`include "md_defs.svh"

module tb_md_pipeline;

  typedef struct packed {
    logic [7:0]  idx;
    logic        chk;
    logic        waw;
    logic        we;
    logic [4:0]  rd;
    logic [31:0] data;
    logic [31:0] pc;
  } exp_t;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   flush_i;
  logic                   us_valid_i;
  logic [`MD_XLEN-1:0]    insn_i;
  logic [`MD_XLEN-1:0]    pc_i;
  logic [`MD_XLEN-1:0]    rs1_data_i;
  logic [`MD_XLEN-1:0]    rs2_data_i;
  logic                   rdy_o;
  logic                   waw_valid_i;
  logic [`MD_RADDR_W-1:0] waw_rd_i;
  logic                   ds_rdy_i;
  logic                   valid_o;
  logic                   wb_we_o;
  logic [`MD_RADDR_W-1:0] wb_rd_o;
  logic [`MD_XLEN-1:0]    wb_data_o;
  logic [`MD_XLEN-1:0]    wb_pc_o;
  logic [`MD_NREGS-1:0]   fwd_act_o;

  logic [111:0] vec_mem [64];
  int           num_vec;
  exp_t         exp_q[$];
  logic         stall_q;
  logic [63:0]  held_dp;
  logic [63:0]  held_ctl;

  md_pipeline UUT (.*);

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // watchdog scaled by the number of vectors
  initial begin
    wait (rst_ni);
    repeat (num_vec * 40 + 200) @(posedge clk_i);
    abort_run("timeout, pipeline stopped delivering results");
  end

  // commit side checks on every rising edge
  always @(posedge clk_i) begin
    exp_t        e;
    logic [31:0] fwd_exp;
    if (rst_ni && !flush_i) begin
      if (stall_q) begin
        check("stall_data_pc", held_dp, {wb_data_o, wb_pc_o});
        check("stall_we_rd", held_ctl, 64'({wb_we_o, wb_rd_o}));
      end
      if (valid_o) begin
        if (exp_q.size() == 0) begin
          abort_run("result delivered with no instruction outstanding");
        end else begin
          e = exp_q[0];
          check($sformatf("vec%0d_rd", e.idx), 64'(e.rd), 64'(wb_rd_o));
          check($sformatf("vec%0d_pc", e.idx), 64'(e.pc), 64'(wb_pc_o));
          check($sformatf("vec%0d_we", e.idx), 64'(e.we), 64'(wb_we_o));
          if (e.chk) begin
            check($sformatf("vec%0d_data", e.idx), 64'(e.data), 64'(wb_data_o));
          end
          fwd_exp = (e.we && e.rd != 5'd0 && !e.waw) ? (32'd1 << e.rd) : 32'd0;
          check($sformatf("vec%0d_fwd", e.idx), 64'(fwd_exp), 64'(fwd_act_o));
          if (ds_rdy_i) begin
            void'(exp_q.pop_front());
          end
        end
      end else begin
        check("idle_fwd", 64'd0, 64'(fwd_act_o));
      end
    end
    stall_q  <= rst_ni && valid_o && !ds_rdy_i && !flush_i;
    held_dp  <= {wb_data_o, wb_pc_o};
    held_ctl <= 64'({wb_we_o, wb_rd_o});
  end

  initial begin
    int         idx;
    int         cur;
    int         gap;
    logic       after_flush;
    logic [3:0] kind;
    exp_t       e;
    void'($urandom(32'h0fa7_4d19));
    flush_i     <= 1'b0;
    us_valid_i  <= 1'b0;
    insn_i      <= '0;
    pc_i        <= '0;
    rs1_data_i  <= '0;
    rs2_data_i  <= '0;
    waw_valid_i <= 1'b0;
    waw_rd_i    <= '0;
    ds_rdy_i    <= 1'b0;
    rst_ni      <= 1'b0;
    // kind nibble f marks the end of the vectors
    for (int i = 0; i < 64; i++) begin
      vec_mem[i] = {4'hf, 108'(i)};
    end
    $readmemh("dv/md_testdata.txt", vec_mem);
    num_vec = 0;
    while (num_vec < 64 && vec_mem[num_vec][111:108] != 4'hf) begin
      num_vec++;
    end
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    check("reset_valid", 64'd0, 64'(valid_o));
    check("reset_fwd", 64'd0, 64'(fwd_act_o));
    check("reset_rdy", 64'd1, 64'(rdy_o));

    idx = 0;
    cur = 0;
    gap = 0;
    after_flush = 1'b0;
    while (idx < num_vec || us_valid_i || flush_i || after_flush) begin
      @(posedge clk_i);
      ds_rdy_i    <= ($urandom_range(3) != 0);
      waw_valid_i <= 1'b0;
      if (after_flush) begin
        check("flush_valid", 64'd0, 64'(valid_o));
        after_flush = 1'b0;
      end
      if (flush_i) begin
        // everything not yet handed over is gone
        flush_i <= 1'b0;
        exp_q.delete();
        after_flush = 1'b1;
      end else if (us_valid_i && rdy_o) begin
        kind   = vec_mem[cur][111:108];
        e.idx  = 8'(cur);
        e.chk  = (kind != 4'h1);
        e.waw  = (kind == 4'h3);
        e.we   = (kind != 4'h1);
        e.rd   = vec_mem[cur][100:96];
        e.data = vec_mem[cur][31:0];
        e.pc   = pc_i;
        exp_q.push_back(e);
        us_valid_i <= 1'b0;
        if (e.waw) begin
          waw_valid_i <= 1'b1;
          waw_rd_i    <= e.rd;
        end
        gap = int'($urandom_range(2));
      end else if (!us_valid_i && gap > 0) begin
        gap--;
      end else if (!us_valid_i && idx < num_vec) begin
        kind = vec_mem[idx][111:108];
        if (kind == 4'h2) begin
          flush_i  <= 1'b1;
          ds_rdy_i <= 1'b0;
        end else begin
          insn_i <= {(kind == 4'h1) ? 7'h00 : `MD_FUNCT7_M, 5'd2, 5'd1,
                     vec_mem[idx][106:104], vec_mem[idx][100:96], `MD_OPCODE_OP};
          rs1_data_i <= vec_mem[idx][95:64];
          rs2_data_i <= vec_mem[idx][63:32];
          pc_i       <= 32'h1000 + 32'(idx * 4);
          us_valid_i <= 1'b1;
          cur = idx;
        end
        idx++;
      end
    end
    // keep back-pressure random while the last results drain
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
      ds_rdy_i <= ($urandom_range(3) != 0);
    end
    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: dv/md_testdata.txt
// ctrl byte (kind nibble: 0 M op, 1 non-M, 2 flush, 3 M op with WAW; then funct3), rd,
// rs1, rs2, expected result
00_05_00000007_00000006_0000002a
00_06_ffffffff_00000003_fffffffd
01_07_80000000_80000000_40000000
01_08_00010000_00010000_00000001
02_09_ffffffff_ffffffff_ffffffff
03_0a_ffffffff_ffffffff_fffffffe
04_0b_00000014_fffffffd_fffffffa
06_0c_00000014_fffffffd_00000002
04_0d_ffffffec_00000003_fffffffa
06_0e_ffffffec_00000003_fffffffe
05_0f_ffffffff_00000002_7fffffff
07_10_ffffffff_00000002_00000001
05_11_00000064_00000007_0000000e
07_12_00000064_00000007_00000002
// division by zero
04_13_00000005_00000000_ffffffff
06_14_00000005_00000000_00000005
05_15_00000010_00000000_ffffffff
07_16_00000010_00000000_00000010
// signed overflow
04_17_80000000_ffffffff_80000000
06_18_80000000_ffffffff_00000000
10_19_00000001_00000002_00000000
30_1a_00000003_00000004_0000000c
00_00_00000009_00000009_00000051
// long divide cut short by a flush
04_1b_00001000_00000010_00000100
20_00_00000000_00000000_00000000
00_1c_00000002_00000003_00000006
06_1d_00000011_00000005_00000002

// File: project.f
+incdir+include
hw/md_pkg.sv
hw/md_decoder.sv
hw/md_multiplier.sv
hw/md_divider.sv
hw/md_wb_stage.sv
hw/md_pipeline.sv
dv/tb_md_pipeline.sv

// File: Makefile
SRCS = $(shell grep -v '^+' project.f) include/md_defs.svh

obj_dir/Vtb_md_pipeline: project.f $(SRCS)
	verilator --binary --timing --top-module tb_md_pipeline -f project.f -o Vtb_md_pipeline

run: obj_dir/Vtb_md_pipeline
	./obj_dir/Vtb_md_pipeline

clean:
	rm -rf obj_dir

.PHONY: run clean
